// File: arkanoid_input.f
arkanoid_key_pkg.sv
arkanoid_spin_pkg.sv
ps2_key_decoder.sv
paddle_step_gen.sv
spin_accumulator.sv
quadrature_stepper.sv
encoder_arbiter.sv
arkanoid_input_top.sv
tb_clock_gen.sv
tb_arkanoid_input.sv

// File: Bender.yml
package:
  name: arkanoid_input

sources:
  - arkanoid_key_pkg.sv
  - arkanoid_spin_pkg.sv
  - ps2_key_decoder.sv
  - paddle_step_gen.sv
  - spin_accumulator.sv
  - quadrature_stepper.sv
  - encoder_arbiter.sv
  - arkanoid_input_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_arkanoid_input.sv

// File: tb_arkanoid_input.sv
//======================================
// Table-driven testbench for the player input chain
// Key events, paddle holds and encoder edges in one run
//======================================
`timescale 1ns/1ns
`default_nettype none

module tb_arkanoid_input;

	localparam int POLL_CYCLES  = 40;
	localparam int DRAIN_CYCLES = 4;
	localparam int STEP_SLOW    = 4;
	localparam int STEP_FAST    = 9;
	localparam int MAX_ENTRIES  = 24;
	localparam int QUIET_CYCLES = 4 * DRAIN_CYCLES;	// Several drain ticks with no change
	localparam int HOLD_TIMEOUT = 2000;
	localparam int ENC_TIMEOUT  = 4;		// Pin to spinner within 4 cycles
	localparam int ENC_SETTLE   = 4;
	localparam int RST_TIMEOUT  = 100;

	localparam logic [1:0] KIND_KEY  = 2'd0;	// Single PS/2 event
	localparam logic [1:0] KIND_HOLD = 2'd1;	// Direction key held
	localparam logic [1:0] KIND_ENC  = 2'd2;	// Physical encoder edges

	typedef struct packed {
		logic [1:0]                     kind;
		arkanoid_key_pkg::key_code_t    code;
		logic                           pressed;
		logic                           fast;	// Fast key held with the direction
		logic                           dir;	// Right key, or A XOR B
		logic [7:0]                     edges;
		arkanoid_key_pkg::cab_buttons_t exp_btn;
	} entry_t;

	logic                           CLK_12M;
	logic                           rst_n;
	arkanoid_key_pkg::key_event_t   ps2_key;
	logic                           enc_a;
	logic                           enc_b;
	arkanoid_spin_pkg::phase_t      spinner;
	arkanoid_key_pkg::cab_buttons_t buttons;

	entry_t                         tbl [MAX_ENTRIES];
	string                          tbl_name [MAX_ENTRIES];
	int                             n_entries;
	logic                           toggle_q;		// Event toggle as last driven
	arkanoid_spin_pkg::phase_t      emu_model;	// Expected emulated phase
	arkanoid_spin_pkg::phase_t      raw_model;	// Expected encoder phase
	arkanoid_key_pkg::cab_buttons_t btn_model;
	int unsigned                    seed_val;
	int unsigned                    hold;
	int                             idx;
	int                             rst_wait;

	tb_clock_gen #(
		.PERIOD_NS    (20),
		.RESET_CYCLES (16)
	) u_clk (
		.CLK_12M (CLK_12M),
		.rst_n   (rst_n)
	);

	arkanoid_input_top #(
		.POLL_CYCLES  (POLL_CYCLES),
		.DRAIN_CYCLES (DRAIN_CYCLES),
		.STEP_SLOW    (STEP_SLOW),
		.STEP_FAST    (STEP_FAST)
	) u_dut (
		.CLK_12M (CLK_12M),
		.rst_n   (rst_n),
		.ps2_key (ps2_key),
		.enc_a   (enc_a),
		.enc_b   (enc_b),
		.spinner (spinner),
		.buttons (buttons)
	);

	//======================================
	// Failure reporting and the check
	//======================================
	task automatic stop_failed();
		$display("*** FAILED ***");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s", what);
		stop_failed();
	endtask

	task automatic check_value(input string tname, input int expected, input int actual);
		if (expected != actual) begin
			$display("FAIL %s expected %0h actual %0h", tname, expected, actual);
			stop_failed();
		end
	endtask

	// Gray sequence 11 01 00 10, walked forward or back
	function automatic arkanoid_spin_pkg::phase_t phase_next(
		input arkanoid_spin_pkg::phase_t ph,
		input logic                      dir
	);
		arkanoid_spin_pkg::phase_t seq [4];
		int                        pos;
		int                        i;
		seq[0] = 2'b11;
		seq[1] = 2'b01;
		seq[2] = 2'b00;
		seq[3] = 2'b10;
		pos = 0;
		for (i = 0; i < 4; i++) begin
			if (seq[i] == ph) pos = i;
		end
		pos = dir ? (pos + 1) % 4 : (pos + 3) % 4;
		return seq[pos];
	endfunction

	// New event word, toggle flipped
	task automatic drive_key(input arkanoid_key_pkg::key_code_t code, input logic pressed);
		toggle_q = ~toggle_q;
		ps2_key <= {toggle_q, pressed, 1'b0, code};
	endtask

	//======================================
	// Stimulus table
	//======================================
	task automatic add_key(input string name, input arkanoid_key_pkg::key_code_t code,
		input logic pressed, input arkanoid_key_pkg::cab_buttons_t exp_btn);
		tbl[n_entries] = '{kind: KIND_KEY, code: code, pressed: pressed, fast: 1'b0,
			dir: 1'b0, edges: 8'd0, exp_btn: exp_btn};
		tbl_name[n_entries] = name;
		n_entries++;
	endtask

	task automatic add_hold(input string name, input logic dir, input logic fast);
		tbl[n_entries] = '{kind: KIND_HOLD, code: 8'h00, pressed: 1'b0, fast: fast,
			dir: dir, edges: 8'd0, exp_btn: '0};
		tbl_name[n_entries] = name;
		n_entries++;
	endtask

	task automatic add_enc(input string name, input logic dir, input logic [7:0] edges);
		tbl[n_entries] = '{kind: KIND_ENC, code: 8'h00, pressed: 1'b0, fast: 1'b0,
			dir: dir, edges: edges, exp_btn: '0};
		tbl_name[n_entries] = name;
		n_entries++;
	endtask

	// Button bits: fire start1 start2 coin1 coin2 service
	task automatic load_table();
		n_entries = 0;
		add_key("start1_dn",  arkanoid_key_pkg::KEY_START1,  1'b1, 6'b01_0000);
		add_key("coin1_dn",   arkanoid_key_pkg::KEY_COIN1,   1'b1, 6'b01_0100);
		add_key("fire_dn",    arkanoid_key_pkg::KEY_FIRE,    1'b1, 6'b11_0100);
		add_key("unmap_dn",   8'h1C,                         1'b1, 6'b11_0100);
		add_key("start1_up",  arkanoid_key_pkg::KEY_START1,  1'b0, 6'b10_0100);
		add_key("coin2_dn",   arkanoid_key_pkg::KEY_COIN2,   1'b1, 6'b10_0110);
		add_key("service_dn", arkanoid_key_pkg::KEY_SERVICE, 1'b1, 6'b10_0111);
		add_key("start2_dn",  arkanoid_key_pkg::KEY_START2,  1'b1, 6'b10_1111);
		add_key("fire_up",    arkanoid_key_pkg::KEY_FIRE,    1'b0, 6'b00_1111);
		add_key("coin1_up",   arkanoid_key_pkg::KEY_COIN1,   1'b0, 6'b00_1011);
		add_key("unmap_up",   8'h5A,                         1'b0, 6'b00_1011);
		add_key("coin2_up",   arkanoid_key_pkg::KEY_COIN2,   1'b0, 6'b00_1001);
		add_key("start2_up",  arkanoid_key_pkg::KEY_START2,  1'b0, 6'b00_0001);
		add_key("service_up", arkanoid_key_pkg::KEY_SERVICE, 1'b0, 6'b00_0000);
		add_hold("right_slow", 1'b1, 1'b0);
		add_hold("left_fast",  1'b0, 1'b1);
		add_hold("left_slow",  1'b0, 1'b0);
		add_enc("enc_fwd", 1'b1, 8'd5);
		add_enc("enc_rev", 1'b0, 8'd2);
		add_hold("right_back", 1'b1, 1'b0);	// Emulated source takes over again
		add_hold("right_fast", 1'b1, 1'b1);
	endtask

	//======================================
	// Entry runners
	//======================================
	task automatic run_event(input int i);
		@(posedge CLK_12M);
		drive_key(tbl[i].code, tbl[i].pressed);
		@(negedge CLK_12M);
		check_value({tbl_name[i], " early"}, btn_model, buttons);	// Not yet decoded
		@(negedge CLK_12M);
		check_value(tbl_name[i], tbl[i].exp_btn, buttons);
		btn_model = tbl[i].exp_btn;
	endtask

	// Hold, release, then watch the spinner until it goes quiet
	task automatic run_hold(input int i, input int unsigned hold_len);
		entry_t                      e;
		arkanoid_key_pkg::key_code_t dir_key;
		arkanoid_spin_pkg::phase_t   last;
		int unsigned                 press_cyc;
		int unsigned                 rel_cyc;
		int unsigned                 cyc;
		int unsigned                 quiet;
		int                          trans;
		int                          exp_count;
		int                          k;
		logic                        synced;
		logic                        done;
		e         = tbl[i];
		dir_key   = e.dir ? arkanoid_key_pkg::KEY_RIGHT : arkanoid_key_pkg::KEY_LEFT;
		press_cyc = e.fast ? 1 : 0;		// Fast key goes down first
		rel_cyc   = press_cyc + hold_len;
		cyc       = 0;
		quiet     = 0;
		trans     = 0;
		synced    = 1'b0;
		done      = 1'b0;
		last      = spinner;
		while (!done) begin
			@(posedge CLK_12M);
			if (e.fast && cyc == 0) drive_key(arkanoid_key_pkg::KEY_FAST, 1'b1);
			if (cyc == press_cyc) drive_key(dir_key, 1'b1);
			if (cyc == rel_cyc) drive_key(dir_key, 1'b0);
			if (e.fast && cyc == rel_cyc + 1) drive_key(arkanoid_key_pkg::KEY_FAST, 1'b0);
			@(negedge CLK_12M);
			if (!synced) begin
				// Encoder may still own the output
				if (spinner == emu_model) begin
					synced = 1'b1;
					last   = spinner;
				end
			end else if (spinner != last) begin
				check_value({tbl_name[i], " step"}, phase_next(last, e.dir), spinner);
				last  = spinner;
				trans = trans + 1;
				quiet = 0;
			end else begin
				quiet = quiet + 1;
			end
			if (cyc < rel_cyc + 3) quiet = 0;	// Last strobe may still land
			if (synced && quiet >= QUIET_CYCLES) begin
				done = 1'b1;
			end else if (cyc > rel_cyc + HOLD_TIMEOUT) begin
				report_timeout({tbl_name[i], " drain never went quiet"});
			end
			cyc = cyc + 1;
		end
		exp_count = (e.fast ? STEP_FAST : STEP_SLOW) * (hold_len / POLL_CYCLES);
		check_value({tbl_name[i], " count"}, exp_count, trans);
		for (k = 0; k < exp_count; k++) begin
			emu_model = phase_next(emu_model, e.dir);
		end
		check_value({tbl_name[i], " buttons"}, btn_model, buttons);
	endtask

	// One A edge at a time, B set for the wanted direction
	task automatic run_encoder(input int i);
		int   k;
		int   w;
		logic new_a;
		logic seen;
		for (k = 0; k < tbl[i].edges; k++) begin
			@(posedge CLK_12M);
			new_a = ~enc_a;
			enc_a <= new_a;
			enc_b <= new_a ^ tbl[i].dir;
			raw_model = phase_next(raw_model, tbl[i].dir);
			w    = 0;
			seen = 1'b0;
			while (!seen) begin
				@(negedge CLK_12M);
				if (spinner == raw_model) begin
					seen = 1'b1;
				end else if (w >= ENC_TIMEOUT) begin
					report_timeout({tbl_name[i], " edge never reached the spinner"});
				end
				w = w + 1;
			end
			for (w = 0; w < ENC_SETTLE; w++) begin
				@(negedge CLK_12M);
				check_value({tbl_name[i], " hold"}, raw_model, spinner);
			end
		end
	endtask

	//======================================
	// Main sequence
	//======================================
	initial begin
		ps2_key   = '0;
		enc_a     = 1'b1;		// Encoder pins idle high
		enc_b     = 1'b1;
		toggle_q  = 1'b0;
		emu_model = 2'b11;
		raw_model = 2'b11;
		btn_model = '0;
		seed_val  = $urandom(32'ha737);
		load_table();

		rst_wait = 0;
		while (!rst_n) begin
			@(posedge CLK_12M);
			rst_wait = rst_wait + 1;
			if (rst_wait > RST_TIMEOUT) report_timeout("reset was never released");
		end
		@(negedge CLK_12M);
		check_value("reset spinner", 2'b11, spinner);
		check_value("reset buttons", 0, buttons);

		for (idx = 0; idx < n_entries; idx++) begin
			case (tbl[idx].kind)
				KIND_KEY: run_event(idx);
				KIND_HOLD: begin
					hold = POLL_CYCLES + ($urandom % (6 * POLL_CYCLES));
					$display("Entry %s, hold %0d cycles", tbl_name[idx], hold);
					run_hold(idx, hold);
				end
				default: run_encoder(idx);
			endcase
		end

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
//======================================
// Testbench clock and synchronous reset source
//======================================
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic CLK_12M,
	output logic rst_n
);

	// Free-running clock
	initial begin
		CLK_12M = 1'b0;
		forever #(PERIOD_NS / 2) CLK_12M = ~CLK_12M;
	end

	// Reset held low, released on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK_12M);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: arkanoid_input_top.sv
//======================================
// Player input chain, keyboard and encoder to cabinet
// Timing parameters set here and passed down
//======================================
`timescale 1ns/1ns
`default_nettype none

module arkanoid_input_top #(
	parameter int POLL_CYCLES  = 96000,	// About 8 ms at 12 MHz
	parameter int DRAIN_CYCLES = 3000,	// About 4 kHz drain tick
	parameter int STEP_SLOW    = 4,
	parameter int STEP_FAST    = 9
) (
	input  wire                            CLK_12M,
	input  wire                            rst_n,
	input  arkanoid_key_pkg::key_event_t   ps2_key,
	input  wire                            enc_a,
	input  wire                            enc_b,
	output arkanoid_spin_pkg::phase_t      spinner,
	output arkanoid_key_pkg::cab_buttons_t buttons
);

	arkanoid_key_pkg::paddle_keys_t paddle_keys;
	arkanoid_spin_pkg::step_msg_t   step;		// Poller to accumulator and arbiter
	arkanoid_spin_pkg::move_req_t   move;
	arkanoid_spin_pkg::phase_t      emu_phase;
	logic                           take;

	ps2_key_decoder u_key_dec (
		.CLK_12M     (CLK_12M),
		.rst_n       (rst_n),
		.ps2_key     (ps2_key),
		.buttons     (buttons),
		.paddle_keys (paddle_keys)
	);

	paddle_step_gen #(
		.POLL_CYCLES (POLL_CYCLES),
		.STEP_SLOW   (STEP_SLOW),
		.STEP_FAST   (STEP_FAST)
	) u_step_gen (
		.CLK_12M     (CLK_12M),
		.rst_n       (rst_n),
		.paddle_keys (paddle_keys),
		.step        (step)
	);

	spin_accumulator u_accum (
		.CLK_12M (CLK_12M),
		.rst_n   (rst_n),
		.step    (step),
		.take    (take),
		.move    (move)
	);

	quadrature_stepper #(
		.DRAIN_CYCLES (DRAIN_CYCLES)
	) u_quad (
		.CLK_12M   (CLK_12M),
		.rst_n     (rst_n),
		.move      (move),
		.take      (take),
		.emu_phase (emu_phase)
	);

	encoder_arbiter u_enc_arb (
		.CLK_12M   (CLK_12M),
		.rst_n     (rst_n),
		.enc_a     (enc_a),
		.enc_b     (enc_b),
		.step      (step),
		.emu_phase (emu_phase),
		.spinner   (spinner)
	);

endmodule

`default_nettype wire

// File: encoder_arbiter.sv
//======================================
// Physical AB encoder at half resolution
// Picks it or the emulated spinner by last activity
//======================================
`timescale 1ns/1ns
`default_nettype none

module encoder_arbiter (
	input  wire                          CLK_12M,
	input  wire                          rst_n,
	input  wire                          enc_a,
	input  wire                          enc_b,
	input  arkanoid_spin_pkg::step_msg_t step,
	input  arkanoid_spin_pkg::phase_t    emu_phase,
	output arkanoid_spin_pkg::phase_t    spinner
);

	logic [1:0]                a_sync;	// Bit 1 is the settled stage
	logic [1:0]                b_sync;
	logic                      a_prev;
	logic                      b_prev;
	logic                      a_edge;
	logic                      pin_change;
	logic                      ab_dir;
	logic                      use_io;	// Physical encoder owns the output
	arkanoid_spin_pkg::phase_t raw_phase;

	//======================================
	// Pin synchronizers and edge history
	//======================================
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			a_sync <= 2'b11;		// Pins idle high
			b_sync <= 2'b11;
			a_prev <= 1'b1;
			b_prev <= 1'b1;
		end else begin
			a_sync <= {a_sync[0], enc_a};
			b_sync <= {b_sync[0], enc_b};
			a_prev <= a_sync[1];
			b_prev <= b_sync[1];
		end
	end

	assign a_edge     = a_sync[1] ^ a_prev;
	assign pin_change = a_edge | (b_sync[1] ^ b_prev);
	assign ab_dir     = a_sync[1] ^ b_sync[1];	// 1 is positive

	// Only A edges step, halving the counts
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			raw_phase <= arkanoid_spin_pkg::PHASE_IDLE;
		end else if (a_edge) begin
			raw_phase <= arkanoid_spin_pkg::phase_step(raw_phase, ab_dir);
		end
	end

	//======================================
	// Source ownership
	//======================================
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			use_io <= 1'b0;
		end else begin
			if (step.strobe) use_io <= 1'b0;	// Key activity takes over
			if (pin_change) use_io <= 1'b1;		// Pin activity wins a tie
		end
	end

	assign spinner = use_io ? raw_phase : emu_phase;

endmodule

`default_nettype wire

// File: quadrature_stepper.sv
//======================================
// Drains the position as an AB quadrature sequence
// One phase step per divider tick while units remain
//======================================
`timescale 1ns/1ns
`default_nettype none

module quadrature_stepper #(
	parameter int DRAIN_CYCLES = 3000	// Clocks per drain tick
) (
	input  wire                          CLK_12M,
	input  wire                          rst_n,
	input  arkanoid_spin_pkg::move_req_t move,
	output logic                         take,
	output arkanoid_spin_pkg::phase_t    emu_phase
);

	localparam int DIV_W = $clog2(DRAIN_CYCLES + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(DRAIN_CYCLES - 1);

	logic [DIV_W-1:0] tick_div;
	logic             tick_wrap;

	assign tick_wrap = tick_div == DIV_LAST;

	// Consume a unit on each tick with work pending
	assign take = tick_wrap & move.pending;

	//======================================
	// Free-running tick divider
	//======================================
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			tick_div <= '0;
		end else if (tick_wrap) begin
			tick_div <= '0;
		end else begin
			tick_div <= tick_div + 1'b1;
		end
	end

	// Phase register is the state, no separate encoding
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			emu_phase <= arkanoid_spin_pkg::PHASE_IDLE;
		end else if (take) begin
			emu_phase <= arkanoid_spin_pkg::phase_step(emu_phase, move.dir);
		end
	end

endmodule

`default_nettype wire

// File: spin_accumulator.sv
//======================================
// Signed paddle position between poller and drain
//======================================
`timescale 1ns/1ns
`default_nettype none

module spin_accumulator (
	input  wire                          CLK_12M,
	input  wire                          rst_n,
	input  arkanoid_spin_pkg::step_msg_t step,
	input  wire                          take,
	output arkanoid_spin_pkg::move_req_t move
);

	arkanoid_spin_pkg::position_t pos;		// Units still to drain
	arkanoid_spin_pkg::position_t add_amt;
	arkanoid_spin_pkg::position_t take_amt;
	logic                         near_wrap;

	// Top two bits apart means close to the signed limit
	assign near_wrap = pos[11] ^ pos[10];

	//======================================
	// Next-state terms
	//======================================
	always_comb begin
		add_amt  = '0;
		take_amt = '0;
		if (step.strobe && !near_wrap) begin
			add_amt = arkanoid_spin_pkg::position_t'(step.amount);
		end
		if (take) begin
			// One unit toward zero
			take_amt = pos[11] ? arkanoid_spin_pkg::position_t'(1)
			                   : arkanoid_spin_pkg::position_t'(-1);
		end
	end

	// Step and take may land together
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			pos <= '0;
		end else begin
			pos <= pos + add_amt + take_amt;
		end
	end

	assign move.pending = pos != '0;	// Drain until empty
	assign move.dir     = ~pos[11];		// Positive sign

endmodule

`default_nettype wire

// File: paddle_step_gen.sv
//======================================
// Held left/right keys to periodic signed steps
// Mimics a mouse poll, one step per period
//======================================
`timescale 1ns/1ns
`default_nettype none

module paddle_step_gen #(
	parameter int POLL_CYCLES = 96000,	// Clocks per poll
	parameter int STEP_SLOW   = 4,
	parameter int STEP_FAST   = 9
) (
	input  wire                            CLK_12M,
	input  wire                            rst_n,
	input  arkanoid_key_pkg::paddle_keys_t paddle_keys,
	output arkanoid_spin_pkg::step_msg_t   step
);

	localparam int CNT_W = $clog2(POLL_CYCLES + 1);
	localparam logic [CNT_W-1:0] POLL_LAST = CNT_W'(POLL_CYCLES - 1);

	// Step sizes in the step width
	localparam arkanoid_spin_pkg::step_t AMT_SLOW = arkanoid_spin_pkg::step_t'(STEP_SLOW);
	localparam arkanoid_spin_pkg::step_t AMT_FAST = arkanoid_spin_pkg::step_t'(STEP_FAST);

	logic [CNT_W-1:0]         poll_cnt;
	logic                     dir_held;
	arkanoid_spin_pkg::step_t mag;		// Unsigned size of the step

	assign dir_held = paddle_keys.left | paddle_keys.right;
	assign mag      = paddle_keys.fast ? AMT_FAST : AMT_SLOW;

	//======================================
	// Poll counter and strobe
	//======================================
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			poll_cnt    <= '0;
			step.strobe <= 1'b0;
		end else begin
			step.strobe <= 1'b0;				// Single-cycle pulse
			if (dir_held) begin
				if (poll_cnt == POLL_LAST) begin
					poll_cnt    <= '0;			// Next period starts here
					step.strobe <= 1'b1;
				end else begin
					poll_cnt <= poll_cnt + 1'b1;
				end
			end else begin
				poll_cnt <= '0;					// Released, restart timing
			end
		end
	end

	// Amount tracks the keys each cycle, valid with the strobe
	always_ff @(posedge CLK_12M) begin
		step.amount <= paddle_keys.right ? mag : -mag;	// Right wins over left
	end

endmodule

`default_nettype wire

// File: ps2_key_decoder.sv
//======================================
// PS/2 key events to held cabinet and paddle keys
//======================================
`timescale 1ns/1ns
`default_nettype none

module ps2_key_decoder (
	input  wire                            CLK_12M,
	input  wire                            rst_n,
	input  arkanoid_key_pkg::key_event_t   ps2_key,
	output arkanoid_key_pkg::cab_buttons_t buttons,
	output arkanoid_key_pkg::paddle_keys_t paddle_keys
);

	logic toggle_d;		// Last seen toggle bit
	logic new_event;

	assign new_event = ps2_key.toggle != toggle_d;

	// Edge detect on the toggle bit, tracks the input through reset too
	always_ff @(posedge CLK_12M) begin
		toggle_d <= ps2_key.toggle;	// No stale event out of reset
	end

	//======================================
	// Key state, one register per mapped key
	//======================================
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			buttons     <= '0;
			paddle_keys <= '0;
		end else if (new_event) begin
			case (ps2_key.code)
				arkanoid_key_pkg::KEY_START1:  buttons.start1    <= ps2_key.pressed;
				arkanoid_key_pkg::KEY_START2:  buttons.start2    <= ps2_key.pressed;
				arkanoid_key_pkg::KEY_COIN1:   buttons.coin1     <= ps2_key.pressed;
				arkanoid_key_pkg::KEY_COIN2:   buttons.coin2     <= ps2_key.pressed;
				arkanoid_key_pkg::KEY_SERVICE: buttons.service   <= ps2_key.pressed;
				arkanoid_key_pkg::KEY_FIRE:    buttons.fire      <= ps2_key.pressed;
				arkanoid_key_pkg::KEY_FAST:    paddle_keys.fast  <= ps2_key.pressed;
				arkanoid_key_pkg::KEY_LEFT:    paddle_keys.left  <= ps2_key.pressed;
				arkanoid_key_pkg::KEY_RIGHT:   paddle_keys.right <= ps2_key.pressed;
				default: ;	// Unmapped, state kept
			endcase
		end
	end

endmodule

`default_nettype wire

// File: arkanoid_spin_pkg.sv
//======================================
// Spinner side of the input path
// Position, step and AB phase types plus the phase sequence
//======================================
`default_nettype none

package arkanoid_spin_pkg;

	typedef logic signed [11:0] position_t;	// Undrained paddle units
	typedef logic signed [11:0] step_t;		// Signed step per poll
	typedef logic [1:0] phase_t;				// Bit 1 is A, bit 0 is B

	localparam phase_t PHASE_IDLE = 2'b11;	// Rest phase out of reset

	// Step from the key poller, one-cycle strobe
	typedef struct packed {
		logic  strobe;
		step_t amount;
	} step_msg_t;

	// Drain request toward the quadrature side
	typedef struct packed {
		logic pending;	// Units left to drain
		logic dir;		// 1 when position is positive
	} move_req_t;

	//======================================
	// One AB step in either direction
	//======================================
	// Positive runs 11 01 00 10, negative the reverse
	function automatic phase_t phase_step(phase_t ph, logic dir);
		phase_t nxt;
		case ({dir, ph})
			3'b1_11: nxt = 2'b01;
			3'b1_01: nxt = 2'b00;
			3'b1_00: nxt = 2'b10;
			3'b1_10: nxt = 2'b11;
			3'b0_11: nxt = 2'b10;
			3'b0_10: nxt = 2'b00;
			3'b0_00: nxt = 2'b01;
			default: nxt = 2'b11;	// 0_01 back to rest
		endcase
		return nxt;
	endfunction

endpackage

`default_nettype wire

// File: arkanoid_key_pkg.sv
//======================================
// Keyboard side of the cabinet input path
// Scan codes, PS/2 event word and button groups
//======================================
`default_nettype none

package arkanoid_key_pkg;

	typedef logic [7:0] key_code_t;	// PS/2 set-2 make code

	// Event word from the keyboard host
	typedef struct packed {
		logic      toggle;		// Flips once per new event
		logic      pressed;		// 1 on make, 0 on break
		logic      extended;	// E0-prefixed code
		key_code_t code;
	} key_event_t;

	//======================================
	// Scan-code map
	//======================================
	localparam key_code_t KEY_START1  = 8'h16;	// 1
	localparam key_code_t KEY_START2  = 8'h1E;	// 2
	localparam key_code_t KEY_COIN1   = 8'h2E;	// 5
	localparam key_code_t KEY_COIN2   = 8'h36;	// 6
	localparam key_code_t KEY_SERVICE = 8'h46;	// 9
	localparam key_code_t KEY_FAST    = 8'h11;	// Alt
	localparam key_code_t KEY_LEFT    = 8'h6B;	// Cursor left
	localparam key_code_t KEY_RIGHT   = 8'h74;	// Cursor right
	localparam key_code_t KEY_FIRE    = 8'h29;	// Space

	// Cabinet buttons, all active high
	typedef struct packed {
		logic fire;
		logic start1;
		logic start2;
		logic coin1;
		logic coin2;
		logic service;
	} cab_buttons_t;

	// Keys that drive the paddle
	typedef struct packed {
		logic left;
		logic right;
		logic fast;		// Larger step per poll
	} paddle_keys_t;

endpackage

`default_nettype wire
